// ==== source/sysctl_cfg.svh ====
`ifndef SYSCTL_CFG_SVH
`define SYSCTL_CFG_SVH

// region patterns, compared against the upper address bits
`define SYSCTL_SYS_PAGE  8'h93   // cpu_addr[15:8]
`define SYSCTL_IO_PAGE   8'h92   // cpu_addr[15:8]
`define SYSCTL_VIDEO_HI  9'h120  // cpu_addr[15:7], 0x9000 to 0x907f

// timer array
`define SYSCTL_TIMERS    8
`define SYSCTL_TICK_W    20

// throttle counter, divides by up to 32
`define SYSCTL_DIV_W     5

`endif

// ==== source/sysctl_pkg.sv ====
`default_nettype none

`include "sysctl_cfg.svh"

package sysctl_pkg;

   typedef logic [15:0] cpu_addr_t;                     // cpu address
   typedef logic [7:0]  cpu_data_t;                     // bus byte
   typedef logic [7:0]  reg_offs_t;                     // offset inside a page
   typedef logic [`SYSCTL_TICK_W-1:0] tick_t;           // timer count
   typedef logic [2:0]  speed_t;                        // throttle code
   typedef logic [$clog2(`SYSCTL_TIMERS)-1:0] timer_idx_t;

   // decoded bus regions
   typedef enum logic [2:0] {
      REGION_NONE  = 3'd0,
      REGION_ROM   = 3'd1,
      REGION_RAM   = 3'd2,
      REGION_IO    = 3'd3,
      REGION_VIDEO = 3'd4,
      REGION_SYS   = 3'd5
   } bus_region_e;

endpackage

`default_nettype wire

// ==== source/sys_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;

   sysctl_pkg::reg_offs_t offs;     // low address byte
   sysctl_pkg::cpu_data_t wr_data;
   logic                  wr_en;    // one cycle per write
   logic                  sys_sel;  // address in the system page

   modport master (
      output offs,
      output wr_data,
      output wr_en,
      output sys_sel
   );

   modport slave (
      input offs,
      input wr_data,
      input wr_en,
      input sys_sel
   );

endinterface

`default_nettype wire

// ==== source/interval_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
   input  wire logic              sys_clk,
   input  wire logic              reset_n,
   input  wire logic              enable,
   input  wire logic              reload,
   input  wire logic              irq_ack,
   input  wire sysctl_pkg::tick_t max_ticks,
   output logic                   irq,
   output sysctl_pkg::tick_t      value
);

   logic wrap;

   assign wrap = enable && (value == max_ticks);

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         value <= '0;
      end else if (reload) begin
         value <= '0;
      end else if (wrap) begin
         value <= '0;
      end else if (enable) begin
         value <= value + 1'b1;
      end
   end

   // sticky until acknowledged, a new wrap wins over the ack
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         irq <= 1'b0;
      end else if (wrap && !reload) begin
         irq <= 1'b1;
      end else if (irq_ack) begin
         irq <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== source/sys_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_cfg.svh"

module sys_regs (
   input  wire logic             sys_clk,
   input  wire logic             reset_n,
   sys_bus_if.slave              bus,
   output sysctl_pkg::cpu_data_t rd_data,
   output sysctl_pkg::speed_t    cpu_speed,
   output logic                  irq_n
);

   sysctl_pkg::timer_idx_t    timer_idx;
   sysctl_pkg::tick_t         ticks [`SYSCTL_TIMERS];
   sysctl_pkg::tick_t         value [`SYSCTL_TIMERS];
   sysctl_pkg::tick_t         sel_value;
   sysctl_pkg::cpu_data_t     irq_byte;
   logic [`SYSCTL_TIMERS-1:0] enable;
   logic [`SYSCTL_TIMERS-1:0] reload;
   logic [`SYSCTL_TIMERS-1:0] irq_ack;
   logic [`SYSCTL_TIMERS-1:0] irq;
   logic                      wr;

   assign wr        = bus.sys_sel && bus.wr_en;
   assign sel_value = value[timer_idx];
   assign irq_n     = ~|irq;

   // control registers and strobes
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         cpu_speed <= '0;
         timer_idx <= '0;
         enable    <= '0;
         reload    <= '0;
         irq_ack   <= '0;
      end else begin
         reload  <= '0;  // strobes last one cycle
         irq_ack <= '0;
         if (wr) begin
            case (bus.offs)
               8'h00: cpu_speed <= bus.wr_data[2:0];
               8'h01: timer_idx <= bus.wr_data[2:0];
               8'h05: reload[timer_idx] <= 1'b1;
               8'h06: enable[timer_idx] <= bus.wr_data[0];
               8'h07: irq_ack[timer_idx] <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   // tick limits of the indexed timer
   always_ff @(posedge sys_clk) begin
      if (wr) begin
         case (bus.offs)
            8'h02: ticks[timer_idx][7:0]   <= bus.wr_data;
            8'h03: ticks[timer_idx][15:8]  <= bus.wr_data;
            8'h04: ticks[timer_idx][19:16] <= bus.wr_data[3:0];
            default: ;
         endcase
      end
   end

   // read-back, holds outside the page
   always_ff @(posedge sys_clk) begin
      if (bus.sys_sel) begin
         case (bus.offs)
            8'h00: rd_data <= {5'b0, cpu_speed};
            8'h01: rd_data <= {5'b0, timer_idx};
            8'h02: rd_data <= sel_value[7:0];
            8'h03: rd_data <= sel_value[15:8];
            8'h04: rd_data <= {4'b0, sel_value[19:16]};
            8'h06: rd_data <= {7'b0, enable[timer_idx]};
            8'h07: rd_data <= irq_byte;
            default: rd_data <= '0;
         endcase
      end
   end

   // timer 0 lands in bit 7 for the 6502 bit instruction
   for (genvar i = 0; i < `SYSCTL_TIMERS; i++) begin : g_timer
      assign irq_byte[`SYSCTL_TIMERS-1-i] = irq[i];

      interval_timer u_timer (
         .sys_clk   (sys_clk),
         .reset_n   (reset_n),
         .enable    (enable[i]),
         .reload    (reload[i]),
         .irq_ack   (irq_ack[i]),
         .max_ticks (ticks[i]),
         .irq       (irq[i]),
         .value     (value[i])
      );
   end

endmodule

`default_nettype wire

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_cfg.svh"

module bus_decoder (
   input  wire logic                  sys_clk,
   input  wire logic                  reset_n,
   input  wire sysctl_pkg::cpu_addr_t cpu_addr,
   input  wire logic                  cpu_wr_en,
   input  wire logic                  cpu_rd_req,
   output logic                       sys_sel,
   output sysctl_pkg::bus_region_e    bus_region,
   output logic                       cpu_ready
);

   sysctl_pkg::bus_region_e region;
   logic                    rd_req_q;
   logic                    rd_edge;

   assign sys_sel = (cpu_addr[15:8] == `SYSCTL_SYS_PAGE);
   assign rd_edge = cpu_rd_req && !rd_req_q;

   // priority order, rom first
   always_comb begin
      if (cpu_addr[15:14] == 2'b11) begin
         region = sysctl_pkg::REGION_ROM;
      end else if (!cpu_addr[15] || cpu_addr[15:12] == 4'h8) begin
         region = sysctl_pkg::REGION_RAM;  // 0x0000 to 0x8fff
      end else if (cpu_addr[15:8] == `SYSCTL_IO_PAGE) begin
         region = sysctl_pkg::REGION_IO;
      end else if (cpu_addr[15:7] == `SYSCTL_VIDEO_HI) begin
         region = sysctl_pkg::REGION_VIDEO;
      end else if (sys_sel) begin
         region = sysctl_pkg::REGION_SYS;
      end else begin
         region = sysctl_pkg::REGION_NONE;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rd_req_q   <= 1'b0;
         cpu_ready  <= 1'b1;
         bus_region <= sysctl_pkg::REGION_NONE;
      end else begin
         rd_req_q  <= cpu_rd_req;
         cpu_ready <= !rd_edge;  // one stall cycle per new read
         if (rd_edge || cpu_wr_en) begin
            bus_region <= region;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/cpu_throttle.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_cfg.svh"

module cpu_throttle (
   input  wire logic               sys_clk,
   input  wire logic               reset_n,
   input  wire sysctl_pkg::speed_t cpu_speed,
   output logic                    cpu_clk_en
);

   logic [`SYSCTL_DIV_W-1:0] div_cnt;
   logic                     en_next;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // one pulse per 2**speed cycles
   always_comb begin
      case (cpu_speed)
         3'd0:    en_next = 1'b1;
         3'd1:    en_next = (div_cnt[0] == 1'b0);
         3'd2:    en_next = (div_cnt[1:0] == 2'b0);
         3'd3:    en_next = (div_cnt[2:0] == 3'b0);
         3'd4:    en_next = (div_cnt[3:0] == 4'b0);
         default: en_next = (div_cnt == '0);  // slowest rate
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         cpu_clk_en <= 1'b1;  // speed 0 after reset
      end else begin
         cpu_clk_en <= en_next;
      end
   end

endmodule

`default_nettype wire

// ==== source/sys_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_controller (
   input  wire logic                    sys_clk,
   input  wire logic                    reset_n,
   input  wire sysctl_pkg::cpu_addr_t   cpu_addr,
   input  wire sysctl_pkg::cpu_data_t   cpu_wr_data,
   input  wire logic                    cpu_wr_en,
   input  wire logic                    cpu_rd_req,
   output wire logic                    cpu_ready,
   output wire sysctl_pkg::bus_region_e bus_region,
   output wire sysctl_pkg::cpu_data_t   sys_rd_data,
   output wire logic                    irq_n,
   output wire logic                    cpu_clk_en
);

   sys_bus_if          bus ();
   wire logic          sys_sel;
   sysctl_pkg::speed_t cpu_speed;

   // cpu side of the register page
   assign bus.offs    = cpu_addr[7:0];
   assign bus.wr_data = cpu_wr_data;
   assign bus.wr_en   = cpu_wr_en;
   assign bus.sys_sel = sys_sel;

   bus_decoder u_decoder (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .cpu_addr   (cpu_addr),
      .cpu_wr_en  (cpu_wr_en),
      .cpu_rd_req (cpu_rd_req),
      .sys_sel    (sys_sel),
      .bus_region (bus_region),
      .cpu_ready  (cpu_ready)
   );

   sys_regs u_regs (
      .sys_clk   (sys_clk),
      .reset_n   (reset_n),
      .bus       (bus.slave),
      .rd_data   (sys_rd_data),
      .cpu_speed (cpu_speed),
      .irq_n     (irq_n)
   );

   cpu_throttle u_throttle (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .cpu_speed  (cpu_speed),
      .cpu_clk_en (cpu_clk_en)
   );

endmodule

`default_nettype wire

// ==== bench/sys_controller_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_cfg.svh"

module sys_controller_checker (
   input wire logic                      sys_clk,
   input wire logic                      reset_n,
   input wire logic                      cpu_ready,
   input wire logic                      irq_n,
   input wire logic                      cpu_clk_en,
   input wire sysctl_pkg::speed_t        cpu_speed,
   input wire logic [`SYSCTL_TIMERS-1:0] timer_irq
);

   int failures = 0;  // failed assertions so far

   // a read edge stalls the cpu for one cycle only
   ready_stall: assert property (@(posedge sys_clk) disable iff (!reset_n)
      !cpu_ready |=> cpu_ready)
      else begin
         failures++;
         $error("cpu_ready low for two cycles in a row");
      end

   irq_gather: assert property (@(posedge sys_clk) disable iff (!reset_n)
      irq_n == !(|timer_irq))
      else begin
         failures++;
         $error("irq_n does not follow the timer interrupts");
      end

   full_speed: assert property (@(posedge sys_clk) disable iff (!reset_n)
      (cpu_speed == 3'd0) |=> cpu_clk_en)  // enable is registered
      else begin
         failures++;
         $error("cpu_clk_en low at speed 0");
      end

endmodule

bind sys_controller sys_controller_checker u_checker (
   .sys_clk    (sys_clk),
   .reset_n    (reset_n),
   .cpu_ready  (cpu_ready),
   .irq_n      (irq_n),
   .cpu_clk_en (cpu_clk_en),
   .cpu_speed  (cpu_speed),
   .timer_irq  (u_regs.irq)
);

`default_nettype wire

// ==== bench/sys_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_controller_tb;

   localparam logic [2:0] OP_WR = 3'd0;
   localparam logic [2:0] OP_RD = 3'd1;
   localparam logic [2:0] OP_RCHK = 3'd2;
   localparam logic [2:0] OP_SAME = 3'd3;
   localparam logic [2:0] OP_IRQ = 3'd4;
   localparam logic [2:0] OP_IRQN = 3'd5;
   localparam logic [2:0] OP_WAIT = 3'd6;
   localparam logic [2:0] OP_CLKEN = 3'd7;

   typedef struct packed {
      logic [2:0]  op;
      logic [15:0] addr;
      logic [7:0]  data;   // write byte, wait length or irq_n level
      logic [7:0]  exp;
   } step_t;

   logic                         sys_clk;
   logic                         reset_n;
   sysctl_pkg::cpu_addr_t        cpu_addr;
   sysctl_pkg::cpu_data_t        cpu_wr_data;
   logic                         cpu_wr_en;
   logic                         cpu_rd_req;
   wire logic                    cpu_ready;
   wire logic                    irq_n;
   wire logic                    cpu_clk_en;
   wire sysctl_pkg::bus_region_e bus_region;
   wire sysctl_pkg::cpu_data_t   sys_rd_data;
   step_t                        steps [0:159];
   int                           n_steps = 0;
   int                           errors = 0;
   int                           checks = 0;
   int                           watchdog_cycles = 0;
   logic [31:0]                  seed = 32'h45ec;

   sys_controller uut (.*);

   initial begin
      sys_clk = 1'b0;
      forever #50 sys_clk = ~sys_clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // priority order of the address map
   function automatic sysctl_pkg::bus_region_e expected_region(input logic [15:0] a);
      if (a >= 16'hc000) return sysctl_pkg::REGION_ROM;
      if (a <= 16'h8fff) return sysctl_pkg::REGION_RAM;
      if (a[15:8] == 8'h92) return sysctl_pkg::REGION_IO;
      if (a >= 16'h9000 && a <= 16'h907f) return sysctl_pkg::REGION_VIDEO;
      if (a[15:8] == 8'h93) return sysctl_pkg::REGION_SYS;
      return sysctl_pkg::REGION_NONE;
   endfunction

   function automatic int clock_divisor(input int s);
      return (s <= 4) ? (1 << s) : 32;
   endfunction

   function automatic int step_cycles(input step_t s);
      case (s.op)
         OP_RD:    return 3;
         OP_SAME:  return 4;
         OP_IRQ:   return 2 * s.exp + 10;
         OP_WAIT:  return s.data;
         OP_CLKEN: return 64;
         OP_IRQN:  return 0;
         default:  return 1;
      endcase
   endfunction

   task automatic add_step(input logic [2:0] op, input logic [15:0] addr,
                           input logic [7:0] data, input logic [7:0] exp);
      steps[n_steps] = '{op, addr, data, exp};
      n_steps++;
   endtask

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic load_timer(input logic [2:0] idx, input int m);
      add_step(OP_WR, 16'h9301, {5'd0, idx}, 0);
      add_step(OP_WR, 16'h9302, 8'(m), 0);
      add_step(OP_WR, 16'h9303, 0, 0);
      add_step(OP_WR, 16'h9304, 0, 0);
      add_step(OP_WR, 16'h9305, 0, 0);  // reload
      add_step(OP_WR, 16'h9306, 1, 0);
   endtask

   task automatic build_table();
      logic [15:0] bounds [14] = '{16'h0000, 16'h8fff, 16'h9000, 16'h907f, 16'h9080, 16'h91ff,
         16'h9200, 16'h92ff, 16'h9300, 16'h93ff, 16'h9400, 16'hbfff, 16'hc000, 16'hffff};
      logic [15:0] a;
      logic [2:0]  ta;
      logic [2:0]  tb;
      logic [19:0] t;
      int          w;
      int          ma;
      int          mb;
      add_step(OP_IRQN, 0, 1, 0);
      add_step(OP_RCHK, 16'h9300, 0, 0);  // speed after reset
      foreach (bounds[i]) add_step(OP_RD, bounds[i], 0, {5'd0, expected_region(bounds[i])});
      for (int i = 0; i < 16; i++) begin
         seed = lcg_next(seed);
         a = seed[31:16];
         if (seed[8]) a[15:8] = 8'h90 + {6'd0, seed[10:9]} + {7'd0, seed[11]};  // near the pages
         add_step(OP_RD, a, 0, {5'd0, expected_region(a)});
      end
      seed = lcg_next(seed);
      t = {1'b1, seed[30:12]};  // far too large to wrap here
      w = 5 + seed[28:24];
      add_step(OP_WR, 16'h9300, 8'hfd, 0);
      add_step(OP_RCHK, 16'h9300, 0, 8'h05);
      add_step(OP_WR, 16'h9301, {5'b11111, seed[18:16]}, 0);
      add_step(OP_RCHK, 16'h9301, 0, {5'd0, seed[18:16]});
      add_step(OP_WR, 16'h9302, t[7:0], 0);
      add_step(OP_WR, 16'h9303, t[15:8], 0);
      add_step(OP_WR, 16'h9304, {4'hf, t[19:16]}, 0);
      add_step(OP_RCHK, 16'h9304, 0, 0);
      add_step(OP_WR, 16'h9306, 8'hfe, 0);
      add_step(OP_RCHK, 16'h9306, 0, 0);
      add_step(OP_WR, 16'h9306, 8'h01, 0);
      add_step(OP_RCHK, 16'h9306, 0, 8'h01);
      add_step(OP_WAIT, 0, 8'(w), 0);
      add_step(OP_WR, 16'h9306, 0, 0);
      add_step(OP_RCHK, 16'h9302, 0, 8'(w + 2));  // counted w+2 enabled edges
      add_step(OP_RCHK, 16'h9304, 0, 0);
      seed = lcg_next(seed);
      ta = seed[18:16];
      tb = ta ^ {seed[22:21], 1'b1};
      ma = 3 + seed[27:24];
      mb = 3 + seed[31:28];
      load_timer(ta, ma);
      add_step(OP_IRQ, 0, 0, 8'(ma + 1));
      add_step(OP_RCHK, 16'h9307, 0, 8'h80 >> ta);
      load_timer(tb, mb);
      add_step(OP_WAIT, 0, 40, 0);
      add_step(OP_RCHK, 16'h9307, 0, (8'h80 >> ta) | (8'h80 >> tb));
      add_step(OP_WR, 16'h9306, 0, 0);
      add_step(OP_WR, 16'h9301, {5'd0, ta}, 0);
      add_step(OP_WR, 16'h9306, 0, 0);
      add_step(OP_SAME, 16'h9302, 0, 0);
      add_step(OP_WR, 16'h9307, 0, 0);
      add_step(OP_WAIT, 0, 1, 0);
      add_step(OP_RCHK, 16'h9307, 0, 8'h80 >> tb);
      add_step(OP_IRQN, 0, 0, 0);
      add_step(OP_WR, 16'h9301, {5'd0, tb}, 0);
      add_step(OP_WR, 16'h9307, 0, 0);
      add_step(OP_WAIT, 0, 1, 0);
      add_step(OP_RCHK, 16'h9307, 0, 0);
      add_step(OP_IRQN, 0, 1, 0);
      for (int s = 0; s < 8; s++) begin
         add_step(OP_WR, 16'h9300, 8'(s), 0);
         add_step(OP_CLKEN, 0, 0, 8'(64 / clock_divisor(s)));
      end
   endtask

   task automatic run_step(input step_t s);
      logic [7:0] first;
      int         cnt;
      cnt = 0;
      case (s.op)
         OP_WR: begin
            cpu_addr    = s.addr;
            cpu_wr_data = s.data;
            cpu_wr_en   = 1'b1;
            @(posedge sys_clk);
            #10 cpu_wr_en = 1'b0;
         end
         OP_RD: begin
            cpu_addr   = s.addr;
            cpu_rd_req = 1'b1;
            @(posedge sys_clk);
            #10 check_value("bus_region", bus_region, s.exp);
            check_value("cpu_ready in stall", cpu_ready, 0);
            @(posedge sys_clk);
            #10 check_value("cpu_ready after stall", cpu_ready, 1);
            cpu_rd_req = 1'b0;
            @(posedge sys_clk);
            #10;
         end
         OP_RCHK, OP_SAME: begin
            cpu_addr = s.addr;
            @(posedge sys_clk);
            #10 first = sys_rd_data;
            if (s.op == OP_SAME) begin
               repeat (3) @(posedge sys_clk);
               #10 check_value("frozen timer value", sys_rd_data, first);
            end else begin
               check_value("register read-back", sys_rd_data, s.exp);
            end
         end
         OP_IRQ: begin
            while (irq_n && cnt < 2 * s.exp + 10) begin
               @(posedge sys_clk);
               #10 cnt++;
            end
            if (irq_n) begin
               errors++;
               $display("timer interrupt did not arrive within %0d cycles", cnt);
            end else begin
               check_value("cycles to timer interrupt", cnt, s.exp);
            end
         end
         OP_IRQN: check_value("irq_n", irq_n, s.data[0]);
         OP_WAIT: begin
            repeat (s.data) @(posedge sys_clk);
            #10;
         end
         OP_CLKEN: begin
            repeat (64) begin
               @(posedge sys_clk);
               #10 cnt += cpu_clk_en;
            end
            check_value("clock enables in 64 cycles", cnt, s.exp);
         end
      endcase
   endtask

   initial begin
      int total;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      cpu_rd_req  = 1'b0;
      reset_n     = 1'b0;
      build_table();
      total = 8 + 100;  // reset plus margin
      for (int i = 0; i < n_steps; i++) total += step_cycles(steps[i]);
      watchdog_cycles = total;
      repeat (8) @(posedge sys_clk);
      #10 reset_n = 1'b1;
      check_value("cpu_ready after reset", cpu_ready, 1);
      check_value("bus_region after reset", bus_region, sysctl_pkg::REGION_NONE);
      for (int i = 0; i < n_steps; i++) run_step(steps[i]);
      errors += uut.u_checker.failures;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      #(watchdog_cycles * 100);
      $display("timeout after %0d cycles, checks: %0d, errors: %0d",
               watchdog_cycles, checks, errors);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/sysctl_pkg.sv
source/sys_bus_if.sv
source/interval_timer.sv
source/sys_regs.sv
source/bus_decoder.sv
source/cpu_throttle.sv
source/sys_controller.sv
bench/sys_controller_checker.sv
bench/sys_controller_tb.sv
